//--- source/soc_config.svh
//####################################################################
// Address map and sizing for the peripheral bus.
// Included by the RTL and the testbench wherever fields are decoded.
//####################################################################
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Address fields: region nibble, device nibble, 12-bit device window
`define SOC_REGION_MSB 31
`define SOC_REGION_LSB 28
`define SOC_DEV_MSB 15
`define SOC_DEV_LSB 12
`define SOC_OFS_MSB 11

// Only region that maps devices
`define SOC_REGION_DEVICE 4'h2

// Device numbers
`define SOC_DEV_DISPLAY 4'h1
`define SOC_DEV_USB 4'h4
`define SOC_DEV_KBD 4'h5

// Register offsets inside a device window
`define SOC_OFS_USB_VALID 12'h000
`define SOC_OFS_USB_MSW 12'h004
`define SOC_OFS_USB_LSW 12'h008
`define SOC_OFS_KBD_STATUS 12'h000
`define SOC_OFS_KBD_CODE 12'h004

// Keyboard FIFO holds 2**5 = 32 codes
`define SOC_KBD_FIFO_ADDR_LEN 5
`endif

//--- source/soc_pkg.sv
//####################################################################
// Shared types for the peripheral bus design and its testbench.
// Import with a wildcard import in the module header.
//####################################################################
package soc_pkg;

    // APB address and data words
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // Display byte, also used for PS/2 scan codes
    typedef logic [7:0] byte_t;

    // USB HID report as delivered by the host controller
    // upper word at bits 63..32
    typedef logic [63:0] usb_report_t;

    // Decoder phase tracking
    typedef enum logic [1:0] {
        // No transfer seen yet, or the last one completed
        bus_idle,
        // Setup seen, access cycle expected next
        bus_access,
        // Invalid region touched, stays here until reset
        bus_halted
    } bus_state_e;

endpackage

//--- source/byte_fifo.sv
//####################################################################
// Synchronous byte FIFO, 2**ADDR_LEN entries, head held in a register.
// Caller must not enqueue when full or dequeue when empty.
//####################################################################
`timescale 1ns/1ps

module byte_fifo import soc_pkg::*; #(
    parameter int ADDR_LEN = 5
) (
    input  logic  clk,
    input  logic  reset_i,
    input  byte_t d_i,
    input  logic  enq_i,
    output byte_t q_o,
    input  logic  deq_i,
    output logic  full_o,
    output logic  empty_o
);

    localparam int DEPTH = 1 << ADDR_LEN;
    localparam logic [ADDR_LEN:0] FULL_COUNT = (ADDR_LEN + 1)'(DEPTH);

    byte_t               mem [DEPTH];
    byte_t               head_r;
    logic [ADDR_LEN-1:0] rd_ptr;
    logic [ADDR_LEN-1:0] wr_ptr;
    logic [ADDR_LEN-1:0] rd_next;
    logic [ADDR_LEN:0]   count;
    logic [ADDR_LEN:0]   remain;

    assign rd_next = rd_ptr + ADDR_LEN'(deq_i);
    // Entries still stored once this cycle's dequeue is done
    assign remain  = count - {{ADDR_LEN{1'b0}}, deq_i};

    always_ff @(posedge clk) begin
        if (enq_i) begin
            mem[wr_ptr] <= d_i;
        end
    end

    // Next head comes from storage, or straight from d_i when it lands in an empty queue
    always_ff @(posedge clk) begin
        if (remain != '0) begin
            head_r <= mem[rd_next];
        end else if (enq_i) begin
            head_r <= d_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_next;
            case ({enq_i, deq_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign q_o     = head_r;
    assign full_o  = (count == FULL_COUNT);
    assign empty_o = (count == '0);

    // Writer and reader must respect the flags
    assert property (@(posedge clk) disable iff (reset_i) full_o |-> !enq_i)
        else $error("FIFO enqueue while full");
    assert property (@(posedge clk) disable iff (reset_i) empty_o |-> !deq_i)
        else $error("FIFO dequeue while empty");

endmodule

//--- source/kbd_port.sv
//####################################################################
// PS/2 keyboard port: queues received codes, serves pops from the bus.
// Status is not-empty plus a sticky error, cleared only by reset.
//####################################################################
`timescale 1ns/1ps
`include "soc_config.svh"

module kbd_port import soc_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  byte_t code_i,
    input  logic  strobe_i,
    input  logic  err_i,
    input  logic  pop_i,
    output byte_t code_o,
    output logic  not_empty_o,
    output logic  error_o
);

    byte_t code_in_r;
    logic  enq_req_r;
    logic  deq_r;
    logic  fifo_enq;
    byte_t fifo_q;
    logic  fifo_full;
    logic  fifo_empty;
    byte_t code_r;
    logic  error_r;

    // Full is checked in the push cycle so back-to-back strobes never overflow
    assign fifo_enq = enq_req_r && !fifo_full;

    byte_fifo #(
        .ADDR_LEN (`SOC_KBD_FIFO_ADDR_LEN)
    ) u_fifo (
        .clk     (clk),
        .reset_i (reset_i),
        .d_i     (code_in_r),
        .enq_i   (fifo_enq),
        .q_o     (fifo_q),
        .deq_i   (deq_r),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    // Code is only valid alongside its strobe
    always_ff @(posedge clk) begin
        if (strobe_i) begin
            code_in_r <= code_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enq_req_r <= 1'b0;
            deq_r     <= 1'b0;
            code_r    <= '0;
            error_r   <= 1'b0;
        end else begin
            enq_req_r <= strobe_i;
            // Pop on an empty queue does nothing
            deq_r     <= pop_i && !fifo_empty;
            if (deq_r) begin
                code_r <= fifo_q;
            end
            // Receiver error or a dropped code
            if (err_i || (enq_req_r && fifo_full)) begin
                error_r <= 1'b1;
            end
        end
    end

    assign code_o      = code_r;
    assign not_empty_o = !fifo_empty;
    assign error_o     = error_r;

endmodule

//--- source/apb_decoder.sv
//####################################################################
// APB slave decoder with region check and halt, display latch and mux.
// Every transfer completes in its access cycle with no wait states.
//####################################################################
`timescale 1ns/1ps
`include "soc_config.svh"

module apb_decoder import soc_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,

    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  addr_t       paddr_i,
    input  data_t       pwdata_i,
    output data_t       prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,

    output byte_t       display_o,
    output logic        halt_o,

    input  usb_report_t usb_report_i,
    input  logic        usb_report_valid_i,

    input  byte_t       kbd_code_i,
    input  logic        kbd_not_empty_i,
    input  logic        kbd_error_i,
    output logic        kbd_pop_o
);

    bus_state_e  state;
    logic        setup;
    logic        access;
    logic        halted;
    logic        region_ok;
    logic [3:0]  dev;
    logic [11:0] ofs;
    logic        dev_write;
    byte_t       display_r;
    data_t       rdata;

    assign setup     = psel_i && !penable_i;
    assign access    = psel_i && penable_i;
    assign halted    = (state == bus_halted);
    assign region_ok = (paddr_i[`SOC_REGION_MSB:`SOC_REGION_LSB] == `SOC_REGION_DEVICE);
    assign dev       = paddr_i[`SOC_DEV_MSB:`SOC_DEV_LSB];
    assign ofs       = paddr_i[`SOC_OFS_MSB:0];

    // No wait states and an error on a bad region or once halted
    assign pready_o  = access;
    assign pslverr_o = access && (halted || !region_ok);
    assign halt_o    = halted;

    // Writes only take effect on a good access
    assign dev_write = access && pwrite_i && region_ok && !halted;
    assign kbd_pop_o = dev_write && (dev == `SOC_DEV_KBD) && (ofs == `SOC_OFS_KBD_STATUS);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= bus_idle;
        end else begin
            case (state)
                bus_idle: begin
                    if (setup) begin
                        state <= bus_access;
                    end
                end
                bus_access: begin
                    // First bad access locks the bus until reset
                    if (access && !region_ok) begin
                        state <= bus_halted;
                    end else begin
                        state <= bus_idle;
                    end
                end
                default: begin
                    state <= bus_halted;
                end
            endcase
        end
    end

    // Display latch takes the low byte at any offset in its window
    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_r <= '0;
        end else if (dev_write && (dev == `SOC_DEV_DISPLAY)) begin
            display_r <= pwdata_i[7:0];
        end
    end

    assign display_o = display_r;

    // Unmapped devices and offsets read zero
    always_comb begin
        rdata = '0;
        if (!pwrite_i && region_ok && !halted) begin
            case (dev)
                `SOC_DEV_DISPLAY: rdata = {24'd0, display_r};
                `SOC_DEV_USB: begin
                    if (ofs == `SOC_OFS_USB_VALID) begin
                        rdata = {31'd0, usb_report_valid_i};
                    end else if (ofs == `SOC_OFS_USB_MSW) begin
                        rdata = usb_report_i[63:32];
                    end else if (ofs == `SOC_OFS_USB_LSW) begin
                        rdata = usb_report_i[31:0];
                    end
                end
                `SOC_DEV_KBD: begin
                    if (ofs == `SOC_OFS_KBD_STATUS) begin
                        rdata = {30'd0, kbd_error_i, kbd_not_empty_i};
                    end else if (ofs == `SOC_OFS_KBD_CODE) begin
                        rdata = {24'd0, kbd_code_i};
                    end
                end
                default: rdata = '0;
            endcase
        end
    end

    assign prdata_o = rdata;

    // Enable only inside a selected transfer
    assert property (@(posedge clk) disable iff (reset_i) penable_i |-> psel_i)
        else $error("APB penable high without psel");

    // Setup is followed by its access with the same address, direction and data
    assert property (@(posedge clk) disable iff (reset_i)
        setup |=> access && $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i))
        else $error("APB transfer changed between setup and access");

endmodule

//--- source/periph_bus.sv
//####################################################################
// Peripheral bus top level: APB slave with display, USB and keyboard.
//####################################################################
`timescale 1ns/1ps

module periph_bus import soc_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,

    // APB slave
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  addr_t       paddr_i,
    input  data_t       pwdata_i,
    output data_t       prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,

    output byte_t       display_o,
    output logic        halt_o,

    // USB report, sampled live on reads
    input  usb_report_t usb_report_i,
    input  logic        usb_report_valid_i,

    // PS/2 keyboard receiver
    input  byte_t       ps2_kbd_code_i,
    input  logic        ps2_kbd_strobe_i,
    input  logic        ps2_kbd_err_i
);

    byte_t kbd_code;
    logic  kbd_not_empty;
    logic  kbd_error;
    logic  kbd_pop;

    apb_decoder u_decoder (
        .clk                (clk),
        .reset_i            (reset_i),
        .psel_i             (psel_i),
        .penable_i          (penable_i),
        .pwrite_i           (pwrite_i),
        .paddr_i            (paddr_i),
        .pwdata_i           (pwdata_i),
        .prdata_o           (prdata_o),
        .pready_o           (pready_o),
        .pslverr_o          (pslverr_o),
        .display_o          (display_o),
        .halt_o             (halt_o),
        .usb_report_i       (usb_report_i),
        .usb_report_valid_i (usb_report_valid_i),
        .kbd_code_i         (kbd_code),
        .kbd_not_empty_i    (kbd_not_empty),
        .kbd_error_i        (kbd_error),
        .kbd_pop_o          (kbd_pop)
    );

    kbd_port u_kbd (
        .clk         (clk),
        .reset_i     (reset_i),
        .code_i      (ps2_kbd_code_i),
        .strobe_i    (ps2_kbd_strobe_i),
        .err_i       (ps2_kbd_err_i),
        .pop_i       (kbd_pop),
        .code_o      (kbd_code),
        .not_empty_o (kbd_not_empty),
        .error_o     (kbd_error)
    );

endmodule

//--- sim/tb_periph_bus.sv
//####################################################################
// Directed testbench for the peripheral bus. Drives APB transfers and
// the USB and PS/2 inputs and checks read data, flags and outputs.
//####################################################################
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_periph_bus import soc_pkg::*; ();

    localparam int FIFO_DEPTH = 1 << `SOC_KBD_FIFO_ADDR_LEN;
    // All tests together take roughly 450 cycles
    localparam int MAX_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    addr_t       paddr;
    data_t       pwdata;
    data_t       prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    byte_t       display_o;
    logic        halt_o;
    usb_report_t usb_report;
    logic        usb_valid;
    byte_t       kbd_code;
    logic        kbd_strobe;
    logic        kbd_err;

    integer      seed = 62;
    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    // Codes the FIFO should hold with the oldest first
    byte_t       expected_codes[$];
    logic        expected_kbd_err = 1'b0;

    periph_bus uut (
        .clk                (clk),
        .reset_i            (reset),
        .psel_i             (psel),
        .penable_i          (penable),
        .pwrite_i           (pwrite),
        .paddr_i            (paddr),
        .pwdata_i           (pwdata),
        .prdata_o           (prdata_o),
        .pready_o           (pready_o),
        .pslverr_o          (pslverr_o),
        .display_o          (display_o),
        .halt_o             (halt_o),
        .usb_report_i       (usb_report),
        .usb_report_valid_i (usb_valid),
        .ps2_kbd_code_i     (kbd_code),
        .ps2_kbd_strobe_i   (kbd_strobe),
        .ps2_kbd_err_i      (kbd_err)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    function automatic addr_t dev_addr(input logic [3:0] dev, input logic [11:0] ofs);
        return {`SOC_REGION_DEVICE, 12'h000, dev, ofs};
    endfunction

    // Setup cycle and then access cycle sampled at the falling edge
    task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                                output data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_flag("pready_o", pready_o, 1'b1);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input data_t wdata, output logic err);
        data_t unused;
        apb_transfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        expected_codes.delete();
        expected_kbd_err = 1'b0;
    endtask

    // A code lands in the FIFO unless it already holds FIFO_DEPTH codes
    task automatic strobe_code(input byte_t code);
        @(posedge clk);
        kbd_code   <= code;
        kbd_strobe <= 1'b1;
        @(posedge clk);
        kbd_strobe <= 1'b0;
        if (expected_codes.size() < FIFO_DEPTH) begin
            expected_codes.push_back(code);
        end else begin
            expected_kbd_err = 1'b1;
        end
    endtask

    task automatic pop_and_check_code();
        data_t rd;
        logic  err;
        byte_t exp;
        apb_write(dev_addr(`SOC_DEV_KBD, `SOC_OFS_KBD_STATUS), '0, err);
        check_flag("pslverr_o", err, 1'b0);
        apb_read(dev_addr(`SOC_DEV_KBD, `SOC_OFS_KBD_CODE), rd, err);
        if (expected_codes.size() == 0) begin
            $display("Popped a key code although no code was expected");
            error_count++;
        end else begin
            exp = expected_codes.pop_front();
            check_data("kbd code", rd, {24'd0, exp});
        end
    endtask

    task automatic read_kbd_status(output data_t status);
        logic err;
        apb_read(dev_addr(`SOC_DEV_KBD, `SOC_OFS_KBD_STATUS), status, err);
        check_flag("pslverr_o", err, 1'b0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", name, error_count - errors_before);
        end
    endtask

    task automatic test_display();
        int    e0;
        data_t rd;
        logic  err;
        e0 = error_count;
        apb_write(dev_addr(`SOC_DEV_DISPLAY, 12'h000), 32'h1234_56a5, err);
        check_flag("pslverr_o", err, 1'b0);
        @(negedge clk);
        check_byte("display_o", display_o, 8'ha5);
        apb_read(dev_addr(`SOC_DEV_DISPLAY, 12'h000), rd, err);
        check_data("prdata_o", rd, 32'h0000_00a5);
        // Device 7 is unmapped
        apb_write(dev_addr(4'h7, 12'h000), 32'h0000_003c, err);
        check_flag("pslverr_o", err, 1'b0);
        apb_read(dev_addr(4'h7, 12'h000), rd, err);
        check_data("prdata_o", rd, 32'h0);
        @(negedge clk);
        check_byte("display_o", display_o, 8'ha5);
        report_test("display", e0);
    endtask

    task automatic test_usb();
        int          e0;
        data_t       rd;
        logic        err;
        data_t       hi;
        data_t       lo;
        data_t       v;
        e0 = error_count;
        hi = $random(seed);
        lo = $random(seed);
        v  = $random(seed);
        @(posedge clk);
        usb_report <= {hi, lo};
        usb_valid  <= v[0];
        apb_read(dev_addr(`SOC_DEV_USB, `SOC_OFS_USB_VALID), rd, err);
        check_data("usb valid", rd, {31'd0, v[0]});
        apb_read(dev_addr(`SOC_DEV_USB, `SOC_OFS_USB_MSW), rd, err);
        check_data("usb msw", rd, hi);
        apb_read(dev_addr(`SOC_DEV_USB, `SOC_OFS_USB_LSW), rd, err);
        check_data("usb lsw", rd, lo);
        // Valid is sampled live and must follow the new level
        @(posedge clk);
        usb_valid <= ~v[0];
        apb_read(dev_addr(`SOC_DEV_USB, `SOC_OFS_USB_VALID), rd, err);
        check_data("usb valid", rd, {31'd0, ~v[0]});
        report_test("usb", e0);
    endtask

    task automatic test_kbd_order();
        int    e0;
        data_t rnd;
        data_t status;
        e0 = error_count;
        for (int i = 0; i < 3; i++) begin
            rnd = $random(seed);
            strobe_code(rnd[7:0]);
        end
        read_kbd_status(status);
        check_flag("kbd not empty", status[0], 1'b1);
        for (int i = 0; i < 3; i++) begin
            pop_and_check_code();
        end
        read_kbd_status(status);
        check_flag("kbd not empty", status[0], 1'b0);
        report_test("kbd order", e0);
    endtask

    task automatic test_kbd_error();
        int    e0;
        data_t rnd;
        data_t status;
        e0 = error_count;
        @(posedge clk);
        kbd_err <= 1'b1;
        @(posedge clk);
        kbd_err <= 1'b0;
        expected_kbd_err = 1'b1;
        read_kbd_status(status);
        check_flag("kbd error", status[1], 1'b1);
        // One more code than the FIFO holds so the last is dropped
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            rnd = $random(seed);
            strobe_code(rnd[7:0]);
        end
        read_kbd_status(status);
        check_data("kbd status", status, {30'd0, expected_kbd_err, 1'b1});
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pop_and_check_code();
        end
        read_kbd_status(status);
        check_data("kbd status", status, {30'd0, expected_kbd_err, 1'b0});
        report_test("kbd error", e0);
    endtask

    task automatic test_halt();
        int    e0;
        data_t rd;
        logic  err;
        e0 = error_count;
        apb_write(dev_addr(`SOC_DEV_DISPLAY, 12'h000), 32'h0000_005a, err);
        check_flag("pslverr_o", err, 1'b0);
        // Region 1 is outside the device region
        apb_read(32'h1000_1000, rd, err);
        check_flag("pslverr_o", err, 1'b1);
        check_data("prdata_o", rd, 32'h0);
        @(negedge clk);
        check_flag("halt_o", halt_o, 1'b1);
        apb_read(dev_addr(`SOC_DEV_DISPLAY, 12'h000), rd, err);
        check_flag("pslverr_o", err, 1'b1);
        check_data("prdata_o", rd, 32'h0);
        apb_write(dev_addr(`SOC_DEV_DISPLAY, 12'h000), 32'h0000_0077, err);
        check_flag("pslverr_o", err, 1'b1);
        @(negedge clk);
        check_byte("display_o", display_o, 8'h5a);
        apply_reset();
        @(negedge clk);
        check_flag("halt_o", halt_o, 1'b0);
        check_byte("display_o", display_o, 8'h00);
        apb_write(dev_addr(`SOC_DEV_DISPLAY, 12'h000), 32'h0000_003c, err);
        check_flag("pslverr_o", err, 1'b0);
        apb_read(dev_addr(`SOC_DEV_DISPLAY, 12'h000), rd, err);
        check_flag("pslverr_o", err, 1'b0);
        check_data("prdata_o", rd, 32'h0000_003c);
        report_test("halt", e0);
    endtask

    initial begin
        reset      <= 1'b1;
        psel       <= 1'b0;
        penable    <= 1'b0;
        pwrite     <= 1'b0;
        paddr      <= '0;
        pwdata     <= '0;
        usb_report <= '0;
        usb_valid  <= 1'b0;
        kbd_code   <= '0;
        kbd_strobe <= 1'b0;
        kbd_err    <= 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        test_display();
        test_usb();
        test_kbd_order();
        test_kbd_error();
        test_halt();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/soc_pkg.sv
source/byte_fifo.sv
source/kbd_port.sv
source/apb_decoder.sv
source/periph_bus.sv
sim/tb_periph_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the peripheral bus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_periph_bus -f sim.f -o tb_periph_bus
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

output=$(./obj_dir/tb_periph_bus 2>&1)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -Fqx "=== PASS ===" <<< "$output"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
